/* hdl/masku_config.svh */
// Mask unit build parameters
// Lane count, lane width, id, vector length and address widths,
// and the depth of the result FIFO

`ifndef MASKU_CONFIG_SVH
`define MASKU_CONFIG_SVH

// Datapath shape, one word is lanes times element width
`define MASKU_NR_LANES 2
`define MASKU_ELEN 64

// Instruction tag and length fields
`define MASKU_VID_W 3
`define MASKU_VL_W 11

// Result address and output buffering
`define MASKU_ADDR_W 8
`define MASKU_RES_DEPTH 2

`endif

/* hdl/masku_pkg.sv */
// Shared mask unit types
// Word, id, length and address vectors, the queued result record
// and the control FSM states

`include "masku_config.svh"

package masku_pkg;

  //////////////////////////////////////////////////////////////////////
  // Vector types
  //////////////////////////////////////////////////////////////////////

  // Full register word, lanes packed side by side without shuffling
  typedef logic [`MASKU_NR_LANES*`MASKU_ELEN-1:0] word_t;

  // Instruction tag
  typedef logic [`MASKU_VID_W-1:0] vid_t;

  // Vector length, also used for the bits still to be issued
  typedef logic [`MASKU_VL_W-1:0] vlen_t;

  // Destination word address
  typedef logic [`MASKU_ADDR_W-1:0] addr_t;

  //////////////////////////////////////////////////////////////////////
  // Records and states
  //////////////////////////////////////////////////////////////////////

  // One merged result word as held in the output FIFO
  typedef struct packed {
    word_t wdata;
    addr_t addr;
    vid_t  id;
  } result_t;

  // Instruction control FSM
  typedef enum logic [1:0] {
    IDLE,
    ISSUE,
    DRAIN
  } ctrl_state_e;

endpackage

/* hdl/masku_if.sv */
// Internal mask unit interfaces
// Issue context from control to the operand join, and the tagged
// operand beat from the join to the merge ALU

`timescale 1ns/1ps

interface masku_issue_if;
  import masku_pkg::*;

  // Beat context offered while beats remain to be issued
  logic  valid;
  logic  vm;
  vlen_t bits_left;
  addr_t addr;
  vid_t  id;
  // High in the cycle the join takes a beat
  logic  fire;

  modport ctrl (output valid, vm, bits_left, addr, id, input fire);
  modport join_side (input valid, vm, bits_left, addr, id, output fire);
endinterface

interface masku_beat_if;
  import masku_pkg::*;

  // Operands plus issue tag under a valid/ready handshake
  logic  valid;
  word_t a;
  word_t b;
  word_t m;
  vlen_t bits_left;
  addr_t addr;
  vid_t  id;
  logic  ready;

  modport source (output valid, a, b, m, bits_left, addr, id, input ready);
  modport sink (input valid, a, b, m, bits_left, addr, id, output ready);
endinterface

/* hdl/masku_insn_ctrl.sv */
// Instruction control for the mask unit
// Takes one instruction, walks its beats on the issue interface
// and counts committed results until the done pulse

`timescale 1ns/1ps

module masku_insn_ctrl (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             req_valid_i,
  output logic             req_ready_o,
  input  masku_pkg::vid_t  req_id_i,
  input  masku_pkg::vlen_t req_vl_i,
  input  masku_pkg::addr_t req_vd_i,
  input  logic             req_vm_i,
  input  logic             commit_i,
  output logic             done_valid_o,
  output masku_pkg::vid_t  done_id_o,
  masku_issue_if.ctrl      issue
);
  import masku_pkg::*;

  localparam int unsigned WordW   = $bits(word_t);
  localparam int unsigned WordLog = $clog2(WordW);

  ctrl_state_e state_q, state_d;
  logic        vm_q;
  vid_t        id_q;
  vlen_t       bits_left_q;
  addr_t       addr_q;
  vlen_t       commits_left_q;
  logic        done_valid_q;
  logic        done_d;
  logic        req_fire;
  logic        last_issue;
  logic        last_commit;
  vlen_t       req_beats;

  // Only one instruction in flight, so intake is open in IDLE only
  assign req_ready_o = (state_q == IDLE);
  assign req_fire    = req_valid_i && req_ready_o;

  // ceil(vl/W), W is a power of two
  assign req_beats = vlen_t'(req_vl_i >> WordLog) + vlen_t'(|req_vl_i[WordLog-1:0]);

  assign last_issue  = (bits_left_q <= vlen_t'(WordW));
  assign last_commit = (commits_left_q == vlen_t'(1));

  // Issue context towards the operand join
  assign issue.valid     = (state_q == ISSUE);
  assign issue.vm        = vm_q;
  assign issue.bits_left = bits_left_q;
  assign issue.addr      = addr_q;
  assign issue.id        = id_q;

  assign done_valid_o = done_valid_q;
  assign done_id_o    = id_q;

  //////////////////////////////////////////////////////////////////////
  // FSM
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    done_d  = 1'b0;
    unique case (state_q)
      IDLE: if (req_fire) state_d = ISSUE;
      // Last beat handed over, wait for the results to drain
      ISSUE: if (issue.fire && last_issue) state_d = DRAIN;
      DRAIN: begin
        if (commit_i && last_commit) begin
          state_d = IDLE;
          done_d  = 1'b1;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q        <= IDLE;
      done_valid_q   <= 1'b0;
      vm_q           <= 1'b1;
      id_q           <= '0;
      bits_left_q    <= '0;
      addr_q         <= '0;
      commits_left_q <= '0;
    end else begin
      state_q      <= state_d;
      done_valid_q <= done_d;
      if (req_fire) begin
        vm_q           <= req_vm_i;
        id_q           <= req_id_i;
        bits_left_q    <= req_vl_i;
        addr_q         <= req_vd_i;
        commits_left_q <= req_beats;
      end else begin
        // Step to the next word, clear on the last one
        if (issue.fire) begin
          bits_left_q <= last_issue ? '0 : bits_left_q - vlen_t'(WordW);
          addr_q      <= addr_q + addr_t'(1);
        end
        if (commit_i) commits_left_q <= commits_left_q - vlen_t'(1);
      end
    end
  end

  // The join only takes beats that control offers
  assert property (@(posedge clk_i) disable iff (!rst_ni) issue.fire |-> state_q == ISSUE);

  // Output handshakes never exceed the beats of the instruction
  assert property (@(posedge clk_i) disable iff (!rst_ni) commit_i |-> commits_left_q != '0);

endmodule

/* hdl/masku_operand_join.sv */
// Operand join for the mask unit
// Waits for a, b and, for masked instructions, m, then presents
// one beat tagged with the issue context

`timescale 1ns/1ps

module masku_operand_join (
  input  masku_pkg::word_t opa_i,
  input  logic             opa_valid_i,
  output logic             opa_ready_o,
  input  masku_pkg::word_t opb_i,
  input  logic             opb_valid_i,
  output logic             opb_ready_o,
  input  masku_pkg::word_t opm_i,
  input  logic             opm_valid_i,
  output logic             opm_ready_o,
  masku_issue_if.join_side issue,
  masku_beat_if.source     beat
);
  import masku_pkg::*;

  logic need_m;
  logic all_valid;
  logic fire;

  //////////////////////////////////////////////////////////////////////
  // Handshake
  //////////////////////////////////////////////////////////////////////

  // Mask channel matters for masked instructions only
  assign need_m = !issue.vm;

  // Every needed operand present and a beat left to issue
  assign all_valid = issue.valid && opa_valid_i && opb_valid_i && (!need_m || opm_valid_i);

  // Beat valid is independent of the ALU ready
  assign beat.valid = all_valid;
  assign fire       = all_valid && beat.ready;
  assign issue.fire = fire;

  // All used channels pop together
  assign opa_ready_o = fire;
  assign opb_ready_o = fire;
  assign opm_ready_o = fire && need_m;

  //////////////////////////////////////////////////////////////////////
  // Beat payload
  //////////////////////////////////////////////////////////////////////

  assign beat.a = opa_i;
  assign beat.b = opb_i;
  // Unmasked beats show the ALU an all ones mask
  assign beat.m = need_m ? opm_i : '1;

  // Tag from the issue context
  assign beat.bits_left = issue.bits_left;
  assign beat.addr      = issue.addr;
  assign beat.id        = issue.id;

endmodule

/* hdl/masku_merge_alu.sv */
// Merge ALU for the mask unit
// Builds the tail enable, ANDs in the mask and selects a or b
// per bit, registering the word with its address and id

`timescale 1ns/1ps

module masku_merge_alu (
  input  logic               clk_i,
  input  logic               rst_ni,
  masku_beat_if.sink         beat,
  output masku_pkg::result_t res_o,
  output logic               res_valid_o,
  input  logic               res_ready_i
);
  import masku_pkg::*;

  localparam int unsigned WordW   = $bits(word_t);
  localparam int unsigned WordLog = $clog2(WordW);

  word_t   bit_enable;
  word_t   sel;
  word_t   merged;
  result_t res_q;
  logic    valid_q;
  logic    take;

  //////////////////////////////////////////////////////////////////////
  // Bit enable and merge
  //////////////////////////////////////////////////////////////////////

  // Full word inside vl, otherwise only the low bits_left bits
  always_comb begin
    if (beat.bits_left >= vlen_t'(WordW)) begin
      bit_enable = '1;
    end else begin
      bit_enable = (word_t'(1) << beat.bits_left[WordLog-1:0]) - word_t'(1);
    end
  end

  // m is all ones for unmasked beats
  assign sel    = bit_enable & beat.m;
  assign merged = (beat.a & sel) | (beat.b & ~sel);

  //////////////////////////////////////////////////////////////////////
  // Output register
  //////////////////////////////////////////////////////////////////////

  // Take a new beat when empty or when the held one leaves
  assign beat.ready = !valid_q || res_ready_i;
  assign take       = beat.valid && beat.ready;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (take) begin
      valid_q <= 1'b1;
    end else if (res_ready_i) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (take) begin
      res_q.wdata <= merged;
      res_q.addr  <= beat.addr;
      res_q.id    <= beat.id;
    end
  end

  assign res_o       = res_q;
  assign res_valid_o = valid_q;

  // Stalled result holds until the FIFO accepts it
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    res_valid_o && !res_ready_i |=> res_valid_o && $stable(res_o));

endmodule

/* hdl/masku_result_queue.sv */
// Result FIFO for the mask unit
// Circular buffer of merged words, head exposed as the output port

`timescale 1ns/1ps

`include "masku_config.svh"

module masku_result_queue (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  masku_pkg::result_t in_i,
  input  logic               in_valid_i,
  output logic               in_ready_o,
  output logic               res_valid_o,
  input  logic               res_ready_i,
  output masku_pkg::word_t   res_wdata_o,
  output masku_pkg::addr_t   res_addr_o,
  output masku_pkg::vid_t    res_id_o
);
  import masku_pkg::*;

  localparam int unsigned Depth = `MASKU_RES_DEPTH;
  localparam int unsigned PtrW  = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntW  = $clog2(Depth + 1);

  result_t         mem_q [Depth];
  logic [PtrW-1:0] wr_ptr_q, rd_ptr_q;
  logic [CntW-1:0] count_q;
  logic            push;
  logic            pop;

  // Full and empty from the entry count
  assign in_ready_o  = (count_q != CntW'(Depth));
  assign res_valid_o = (count_q != '0);

  assign push = in_valid_i && in_ready_o;
  assign pop  = res_valid_o && res_ready_i;

  // Storage
  always_ff @(posedge clk_i) begin
    if (push) mem_q[wr_ptr_q] <= in_i;
  end

  //////////////////////////////////////////////////////////////////////
  // Pointers and count
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PtrW'(Depth - 1)) ? '0 : wr_ptr_q + PtrW'(1);
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrW'(Depth - 1)) ? '0 : rd_ptr_q + PtrW'(1);
      end
      // Simultaneous push and pop keep the count
      if (push && !pop) count_q <= count_q + CntW'(1);
      else if (pop && !push) count_q <= count_q - CntW'(1);
    end
  end

  // Head entry
  assign res_wdata_o = mem_q[rd_ptr_q].wdata;
  assign res_addr_o  = mem_q[rd_ptr_q].addr;
  assign res_id_o    = mem_q[rd_ptr_q].id;

  // A full FIFO takes no write, so its write pointer stays put
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    count_q == CntW'(Depth) |=> $stable(wr_ptr_q));

endmodule

/* hdl/masku_top.sv */
// Mask unit top level
// Instruction control, operand join, merge ALU and result FIFO
// behind plain request, operand, result and done ports

`timescale 1ns/1ps

module masku_top (
  input  logic             clk_i,
  input  logic             rst_ni,
  // Instruction request
  input  logic             req_valid_i,
  output logic             req_ready_o,
  input  masku_pkg::vid_t  req_id_i,
  input  masku_pkg::vlen_t req_vl_i,
  input  masku_pkg::addr_t req_vd_i,
  input  logic             req_vm_i,
  // Operand channels
  input  masku_pkg::word_t opa_i,
  input  logic             opa_valid_i,
  output logic             opa_ready_o,
  input  masku_pkg::word_t opb_i,
  input  logic             opb_valid_i,
  output logic             opb_ready_o,
  input  masku_pkg::word_t opm_i,
  input  logic             opm_valid_i,
  output logic             opm_ready_o,
  // Result words
  output logic             res_valid_o,
  input  logic             res_ready_i,
  output masku_pkg::word_t res_wdata_o,
  output masku_pkg::addr_t res_addr_o,
  output masku_pkg::vid_t  res_id_o,
  // Completion
  output logic             done_valid_o,
  output masku_pkg::vid_t  done_id_o
);
  import masku_pkg::*;

  masku_issue_if issue_if ();
  masku_beat_if  beat_if ();

  result_t alu_res;
  logic    alu_res_valid;
  logic    alu_res_ready;
  logic    commit;

  // Every output handshake retires one word
  assign commit = res_valid_o && res_ready_i;

  masku_insn_ctrl i_insn_ctrl (
    .clk_i, .rst_ni,
    .req_valid_i, .req_ready_o, .req_id_i, .req_vl_i, .req_vd_i, .req_vm_i,
    .commit_i (commit),
    .done_valid_o, .done_id_o,
    .issue    (issue_if)
  );

  masku_operand_join i_operand_join (
    .opa_i, .opa_valid_i, .opa_ready_o,
    .opb_i, .opb_valid_i, .opb_ready_o,
    .opm_i, .opm_valid_i, .opm_ready_o,
    .issue (issue_if),
    .beat  (beat_if)
  );

  masku_merge_alu i_merge_alu (
    .clk_i, .rst_ni,
    .beat        (beat_if),
    .res_o       (alu_res),
    .res_valid_o (alu_res_valid),
    .res_ready_i (alu_res_ready)
  );

  masku_result_queue i_result_queue (
    .clk_i, .rst_ni,
    .in_i       (alu_res),
    .in_valid_i (alu_res_valid),
    .in_ready_o (alu_res_ready),
    .res_valid_o, .res_ready_i, .res_wdata_o, .res_addr_o, .res_id_o
  );

endmodule

/* testbench/tb_masku.sv */
// Testbench for the mask unit top level
// Clock and reset, LFSR driven requests, operands and back-pressure,
// a bit level merge model, the compare task and the cycle timeout

`timescale 1ns/1ps

module tb_masku;
  import masku_pkg::*;

  localparam int unsigned W       = $bits(word_t);
  localparam int unsigned NumInsn = 12;
  localparam int unsigned MaxBeat = 8;
  // Beats the DUT can hold in the ALU register and the two entry result FIFO
  localparam int unsigned HoldSlots = 3;

  logic  clk_i = 1'b0;
  logic  rst_ni;
  logic  req_valid_i, req_ready_o, req_vm_i;
  vid_t  req_id_i;
  vlen_t req_vl_i;
  addr_t req_vd_i;
  word_t opa_i, opb_i, opm_i;
  logic  opa_valid_i, opa_ready_o, opb_valid_i, opb_ready_o, opm_valid_i, opm_ready_o;
  logic  res_valid_o, res_ready_i;
  word_t res_wdata_o;
  addr_t res_addr_o;
  vid_t  res_id_o;
  logic  done_valid_o;
  vid_t  done_id_o;

  // Instruction list drawn before reset
  vlen_t vl_arr [NumInsn];
  logic  vm_arr [NumInsn];
  addr_t vd_arr [NumInsn];
  vid_t  id_arr [NumInsn];

  // Operands and expected results of the running instruction
  word_t a_arr [MaxBeat];
  word_t b_arr [MaxBeat];
  word_t m_arr [MaxBeat];
  word_t exp_arr [MaxBeat];
  addr_t exp_addr [MaxBeat];

  logic        [31:0] lfsr_q = 32'hf742;
  int unsigned        cycle_cnt = 0;
  int unsigned        cycle_limit = 32'hffff_ffff;
  int unsigned        nbeats, op_idx, res_idx, in_flight;
  logic               a_v, b_v, m_v, popped, done_due, done_seen;

  masku_top DUT (.*);

  always #5 clk_i = ~clk_i;

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  // Fibonacci LFSR with taps 32 22 2 1 stepped once per bit
  function automatic logic rand_bit();
    logic fb;
    fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
    lfsr_q = {lfsr_q[30:0], fb};
    return lfsr_q[0];
  endfunction

  function automatic word_t rand_bits(input int unsigned n);
    word_t r;
    r = '0;
    for (int unsigned i = 0; i < n; i++) begin
      r = {r[W-2:0], rand_bit()};
    end
    return r;
  endfunction

  function automatic int unsigned beats_of(input vlen_t vl);
    return (int'(vl) + W - 1) / W;
  endfunction

  // Element k*W+g enabled below vl and, when masked, by its m bit
  function automatic word_t merge_model(input word_t a, input word_t b, input word_t m,
                                        input int unsigned k, input vlen_t vl,
                                        input logic vm);
    word_t r;
    logic  en;
    for (int unsigned g = 0; g < W; g++) begin
      en   = (k * W + g < int'(vl)) && (vm || m[g]);
      r[g] = en ? a[g] : b[g];
    end
    return r;
  endfunction

  task automatic check_value(input string name, input word_t exp, input word_t act);
    if (act !== exp) begin
      $display("ERROR %s expected %0h actual %0h", name, exp, act);
      $display("*** TEST FAILED ***");
      $fatal(1, "Mismatch in %s", name);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Stimulus and sampling
  //////////////////////////////////////////////////////////////////////

  task automatic build_operands(input int unsigned t);
    for (int unsigned k = 0; k < nbeats; k++) begin
      a_arr[k]    = rand_bits(W);
      b_arr[k]    = rand_bits(W);
      m_arr[k]    = rand_bits(W);
      exp_arr[k]  = merge_model(a_arr[k], b_arr[k], m_arr[k], k, vl_arr[t], vm_arr[t]);
      exp_addr[k] = vd_arr[t] + addr_t'(k);
    end
  endtask

  // Runs 1 ns after the edge
  // A valid once raised holds until taken
  task automatic drive_inputs(input int unsigned t);
    if (popped) begin
      op_idx = op_idx + 1;
      a_v    = 1'b0;
      b_v    = 1'b0;
      m_v    = 1'b0;
      popped = 1'b0;
    end
    if (op_idx < nbeats) begin
      if (!a_v) a_v = rand_bit();
      if (!b_v) b_v = rand_bit();
      if (!m_v && !vm_arr[t]) m_v = rand_bit();
    end
    opa_valid_i = a_v;
    opb_valid_i = b_v;
    opm_valid_i = m_v;
    opa_i       = (op_idx < nbeats) ? a_arr[op_idx] : '0;
    opb_i       = (op_idx < nbeats) ? b_arr[op_idx] : '0;
    opm_i       = (op_idx < nbeats) ? m_arr[op_idx] : '0;
    res_ready_i = rand_bit();
  endtask

  // Runs at the falling edge and sees the handshakes of the next rising edge
  task automatic sample_outputs(input int unsigned t);
    logic take;
    // All needed operands present and room left in the DUT
    take = (op_idx < nbeats) && a_v && b_v && (vm_arr[t] || m_v) &&
           (in_flight < HoldSlots);
    check_value($sformatf("insn %0d done_valid", t), word_t'(done_due), word_t'(done_valid_o));
    if (done_due) begin
      check_value($sformatf("insn %0d done_id", t), word_t'(id_arr[t]), word_t'(done_id_o));
      check_value($sformatf("insn %0d req_ready at done", t), 1, word_t'(req_ready_o));
      done_seen = 1'b1;
      done_due  = 1'b0;
    end else begin
      check_value($sformatf("insn %0d req_ready busy", t), 0, word_t'(req_ready_o));
    end
    // Used operand channels pop together and m never for unmasked
    check_value($sformatf("insn %0d opa_ready", t), word_t'(take), word_t'(opa_ready_o));
    check_value($sformatf("insn %0d opb_ready", t), word_t'(take), word_t'(opb_ready_o));
    check_value($sformatf("insn %0d opm_ready", t), word_t'(take && !vm_arr[t]),
                word_t'(opm_ready_o));
    if (take) begin
      popped    = 1'b1;
      in_flight = in_flight + 1;
    end
    if (res_valid_o && res_ready_i) begin
      check_value($sformatf("insn %0d extra result", t), 1, word_t'(res_idx < nbeats));
      check_value($sformatf("insn %0d beat %0d wdata", t, res_idx), exp_arr[res_idx],
                  res_wdata_o);
      check_value($sformatf("insn %0d beat %0d addr", t, res_idx), word_t'(exp_addr[res_idx]),
                  word_t'(res_addr_o));
      check_value($sformatf("insn %0d beat %0d id", t, res_idx), word_t'(id_arr[t]),
                  word_t'(res_id_o));
      in_flight = in_flight - 1;
      res_idx   = res_idx + 1;
      if (res_idx == nbeats) done_due = 1'b1;
    end
  endtask

  // Starts and ends 1 ns after a rising edge
  task automatic run_insn(input int unsigned t);
    nbeats = beats_of(vl_arr[t]);
    build_operands(t);
    req_valid_i = 1'b1;
    req_vl_i    = vl_arr[t];
    req_vm_i    = vm_arr[t];
    req_vd_i    = vd_arr[t];
    req_id_i    = id_arr[t];
    @(negedge clk_i);
    // Also proves the previous done pulse lasted one cycle
    check_value($sformatf("insn %0d req_ready idle", t), 1, word_t'(req_ready_o));
    check_value($sformatf("insn %0d done_valid idle", t), 0, word_t'(done_valid_o));
    @(posedge clk_i);
    #1;
    req_valid_i = 1'b0;
    op_idx      = 0;
    res_idx     = 0;
    in_flight   = 0;
    a_v         = 1'b0;
    b_v         = 1'b0;
    m_v         = 1'b0;
    popped      = 1'b0;
    done_due    = 1'b0;
    done_seen   = 1'b0;
    while (!done_seen) begin
      drive_inputs(t);
      @(negedge clk_i);
      sample_outputs(t);
      @(posedge clk_i);
      #1;
    end
    opa_valid_i = 1'b0;
    opb_valid_i = 1'b0;
    opm_valid_i = 1'b0;
    res_ready_i = 1'b0;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence and timeout
  //////////////////////////////////////////////////////////////////////

  initial begin
    int unsigned total_beats;
    rst_ni      = 1'b0;
    req_valid_i = 1'b0;
    req_vm_i    = 1'b1;
    req_id_i    = '0;
    req_vl_i    = '0;
    req_vd_i    = '0;
    opa_i       = '0;
    opb_i       = '0;
    opm_i       = '0;
    opa_valid_i = 1'b0;
    opb_valid_i = 1'b0;
    opm_valid_i = 1'b0;
    res_ready_i = 1'b0;
    total_beats = 0;
    // vl from 1 to 8 words
    for (int unsigned t = 0; t < NumInsn; t++) begin
      vl_arr[t]   = vlen_t'(rand_bits(10)) + vlen_t'(1);
      vm_arr[t]   = rand_bit();
      vd_arr[t]   = addr_t'(rand_bits($bits(addr_t)));
      id_arr[t]   = vid_t'(rand_bits($bits(vid_t)));
      total_beats = total_beats + beats_of(vl_arr[t]);
    end
    cycle_limit = 40 * total_beats + 100;
    repeat (3) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    @(negedge clk_i);
    check_value("reset req_ready", 1, word_t'(req_ready_o));
    check_value("reset res_valid", 0, word_t'(res_valid_o));
    check_value("reset done_valid", 0, word_t'(done_valid_o));
    check_value("reset operand readies", 0, word_t'({opa_ready_o, opb_ready_o, opm_ready_o}));
    @(posedge clk_i);
    #1;
    for (int unsigned t = 0; t < NumInsn; t++) begin
      run_insn(t);
    end
    $display("*** TEST PASSED ***");
    $finish;
  end

  always @(posedge clk_i) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      $display("Run timed out after %0d cycles without finishing all instructions", cycle_cnt);
      $display("*** TEST FAILED ***");
      $fatal(1, "Timeout");
    end
  end

endmodule

/* filelist.f */
+incdir+hdl
hdl/masku_pkg.sv
hdl/masku_if.sv
hdl/masku_insn_ctrl.sv
hdl/masku_operand_join.sv
hdl/masku_merge_alu.sv
hdl/masku_result_queue.sv
hdl/masku_top.sv
testbench/tb_masku.sv

/* Bender.yml */
package:
  name: masku

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/masku_pkg.sv
      - hdl/masku_if.sv
      - hdl/masku_insn_ctrl.sv
      - hdl/masku_operand_join.sv
      - hdl/masku_merge_alu.sv
      - hdl/masku_result_queue.sv
      - hdl/masku_top.sv
  - target: simulation
    files:
      - testbench/tb_masku.sv
